// File: hdl/lm_pkg.sv
package lm_pkg;

  // Field widths for one side of the book
  typedef logic [15:0] price_t;
  typedef logic [7:0]  quantity_t;
  typedef logic [7:0]  uid_t;

  // Room for a full table of maximum quantities plus headroom
  typedef logic [11:0] accum_t;

  // Empty slot markers
  // Ask side uses the top price, bid side the bottom one
  localparam price_t PRICE_MAX = 16'hffff;
  localparam price_t PRICE_MIN = 16'h0000;

  // One resting order, 32 bits
  typedef struct packed {
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } entry_t;

  // Depth query request
  typedef struct packed {
    price_t    price;
    quantity_t quantity;
  } qry_cmd_t;

  // Depth query answer
  typedef struct packed {
    logic   is_ge;
    accum_t qty;
  } qry_rsp_t;

endpackage

// File: hdl/lm_sorted_table.sv
module lm_sorted_table #(
  parameter int N      = 8,
  parameter bit is_ask = 1'b1
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      insert,
  input  lm_pkg::entry_t            insert_entry,
  input  logic                      cancel,
  input  lm_pkg::uid_t              cancel_uid,
  input  logic                      head_pop,
  input  logic                      reject_pop,
  output lm_pkg::entry_t [N-1:0]    entries,
  output logic [N-1:0]              entry_vld,
  output logic                      head_vld,
  output lm_pkg::entry_t            head,
  output logic                      reject_vld,
  output lm_pkg::entry_t            reject,
  output logic                      cancel_hit,
  output lm_pkg::entry_t            cancel_entry
);

  import lm_pkg::*;

  localparam price_t INVALID_PRICE = is_ask ? PRICE_MAX : PRICE_MIN;
  localparam entry_t EMPTY = '{uid: '0, price: INVALID_PRICE, quantity: '0};

  // Slot 0 holds the best price
  entry_t [N-1:0] tbl_q;
  entry_t [N-1:0] tbl_d;
  // Neighbour views for the two shift directions
  entry_t [N-1:0] up_src;
  entry_t [N-1:0] dn_src;

  logic [N-1:0] ins_beat;
  logic [N-1:0] ins_sel;
  logic [N-1:0] ins_shift;
  logic         ins_miss;
  logic         ins_full;
  logic [N-1:0] cxl_match;
  logic [N-1:0] cxl_shift;

  entry_t rej_d;
  logic   rej_vld_d;

  // Strictly better price for this side
  function automatic logic better(price_t x, price_t t);
    return is_ask ? (x < t) : (x > t);
  endfunction

  always_comb begin
    for (int i = 0; i < N; i++) begin
      entry_vld[i] = (tbl_q[i].price != INVALID_PRICE);
    end
  end

  // Insert point is the first slot the new order beats
  // Equal prices do not beat, so the new order queues behind them
  always_comb begin : insert_pick
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < N; i++) begin
      ins_beat[i]  = ~entry_vld[i] | better(insert_entry.price, tbl_q[i].price);
      ins_sel[i]   = ins_beat[i] & ~seen;
      // Slots behind the insert point move toward the tail
      ins_shift[i] = seen;
      seen         = seen | ins_beat[i];
    end
  end

  // Nothing beaten, the new order ranks last in a full table
  assign ins_miss = ~|ins_beat;
  assign ins_full = entry_vld[N-1];

  // UIDs are unique so at most one slot matches
  always_comb begin : cancel_pick
    logic seen;
    seen         = 1'b0;
    cancel_entry = '0;
    for (int i = 0; i < N; i++) begin
      cxl_match[i] = entry_vld[i] & (tbl_q[i].uid == cancel_uid);
      if (cancel && cxl_match[i]) begin
        cancel_entry = cancel_entry | tbl_q[i];
      end
      // Matched slot and everything behind it close the gap
      seen         = seen | cxl_match[i];
      cxl_shift[i] = seen;
    end
  end

  assign cancel_hit = cancel & (|cxl_match);

  always_comb begin
    for (int i = 0; i < N - 1; i++) begin
      up_src[i] = tbl_q[i+1];
    end
    // Tail refills with an empty marker
    up_src[N-1] = EMPTY;
    dn_src[0]   = tbl_q[0];
    for (int i = 1; i < N; i++) begin
      dn_src[i] = tbl_q[i-1];
    end
  end

  // Next table state, one command per cycle
  always_comb begin : table_next
    for (int i = 0; i < N; i++) begin
      tbl_d[i] = tbl_q[i];
      if (insert) begin
        if (ins_sel[i]) begin
          tbl_d[i] = insert_entry;
        end else if (ins_shift[i]) begin
          tbl_d[i] = dn_src[i];
        end
      end else if (cancel_hit && cxl_shift[i]) begin
        tbl_d[i] = up_src[i];
      end else if (head_pop) begin
        tbl_d[i] = up_src[i];
      end
    end
  end

  // Overflow beats a pop in the same cycle
  always_comb begin : reject_next
    rej_d     = reject;
    rej_vld_d = reject_vld;
    if (insert && ins_miss) begin
      rej_d     = insert_entry;
      rej_vld_d = 1'b1;
    end else if (insert && ins_full) begin
      // Worst resting order falls off the tail
      rej_d     = tbl_q[N-1];
      rej_vld_d = 1'b1;
    end else if (reject_pop) begin
      rej_vld_d = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < N; i++) begin
        tbl_q[i] <= EMPTY;
      end
      reject_vld <= 1'b0;
    end else begin
      tbl_q      <= tbl_d;
      reject_vld <= rej_vld_d;
    end
  end

  always_ff @(posedge clk) begin
    reject <= rej_d;
  end

  assign entries  = tbl_q;
  // Head read straight from slot 0
  assign head     = tbl_q[0];
  assign head_vld = entry_vld[0];

endmodule

// File: hdl/lm_query_fsm.sv
module lm_query_fsm (
  input  logic clk,
  input  logic rst,
  input  logic qry_vld,
  input  logic scan_last,
  output logic qry_busy,
  output logic scan_clr,
  output logic scan_step,
  output logic rsp_load
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SCAN,
    ST_RESP
  } state_t;

  state_t state;
  state_t state_nxt;

  // Request taken only from idle
  assign scan_clr  = (state == ST_IDLE) & qry_vld;
  // One slot per cycle while scanning
  assign scan_step = (state == ST_SCAN);
  // Sum is complete in the respond cycle
  assign rsp_load  = (state == ST_RESP);
  assign qry_busy  = (state != ST_IDLE);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: if (qry_vld) state_nxt = ST_SCAN;
      ST_SCAN: if (scan_last) state_nxt = ST_RESP;
      ST_RESP: state_nxt = ST_IDLE;
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

// File: hdl/lm_scan_counter.sv
module lm_scan_counter #(
  parameter int N = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 scan_clr,
  input  logic                 scan_step,
  output logic [$clog2(N)-1:0] scan_idx,
  output logic                 scan_last
);

  // Index of the slot being scanned
  always_ff @(posedge clk) begin
    if (rst || scan_clr) begin
      scan_idx <= '0;
    end else if (scan_step) begin
      scan_idx <= scan_idx + 1'b1;
    end
  end

  // Final slot of the table
  assign scan_last = (scan_idx == ($clog2(N))'(N - 1));

endmodule

// File: hdl/lm_depth_accum.sv
module lm_depth_accum #(
  parameter int N      = 8,
  parameter bit is_ask = 1'b1
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   qry_vld,
  input  lm_pkg::qry_cmd_t       qry_cmd,
  input  logic                   scan_clr,
  input  logic                   scan_step,
  input  logic [$clog2(N)-1:0]   scan_idx,
  input  lm_pkg::entry_t [N-1:0] entries,
  input  logic [N-1:0]           entry_vld,
  input  logic                   rsp_load,
  output logic                   qry_rsp_vld,
  output lm_pkg::qry_rsp_t       qry_rsp
);

  import lm_pkg::*;

  qry_cmd_t cmd_q;
  accum_t   sum_q;
  entry_t   cur;
  logic     cur_hit;
  logic     accept;

  // Request taken by the sequencer this cycle
  assign accept = qry_vld & scan_clr;

  // Slot under the scan index
  assign cur = entries[scan_idx];

  // At or better than the query price
  assign cur_hit = entry_vld[scan_idx] &
                   (is_ask ? (cur.price <= cmd_q.price) : (cur.price >= cmd_q.price));

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= qry_cmd;
      sum_q <= '0;
    end else if (scan_step && cur_hit) begin
      sum_q <= sum_q + accum_t'(cur.quantity);
    end
  end

  // Answer held until the next accepted request
  always_ff @(posedge clk) begin
    if (rst || accept) begin
      qry_rsp_vld <= 1'b0;
    end else if (rsp_load) begin
      qry_rsp_vld <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_load) begin
      qry_rsp.qty   <= sum_q;
      qry_rsp.is_ge <= (sum_q >= accum_t'(cmd_q.quantity));
    end
  end

endmodule

// File: hdl/lm_table_top.sv
module lm_table_top #(
  parameter int N      = 8,
  parameter bit is_ask = 1'b1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              insert,
  input  lm_pkg::entry_t    insert_entry,
  input  logic              cancel,
  input  lm_pkg::uid_t      cancel_uid,
  input  logic              head_pop,
  input  logic              reject_pop,
  input  logic              qry_vld,
  input  lm_pkg::qry_cmd_t  qry_cmd,
  output logic              head_vld,
  output lm_pkg::entry_t    head,
  output logic              reject_vld,
  output lm_pkg::entry_t    reject,
  output logic              cancel_hit,
  output lm_pkg::entry_t    cancel_entry,
  output logic              qry_busy,
  output logic              qry_rsp_vld,
  output lm_pkg::qry_rsp_t  qry_rsp
);

  import lm_pkg::*;

  // Table contents seen by the query scan
  entry_t [N-1:0]         entries;
  logic [N-1:0]           entry_vld;
  // Scan sequencing
  logic                   scan_clr;
  logic                   scan_step;
  logic                   scan_last;
  logic                   rsp_load;
  logic [$clog2(N)-1:0]   scan_idx;

  lm_sorted_table #(.N(N), .is_ask(is_ask)) u_table (
    .clk          (clk),
    .rst          (rst),
    .insert       (insert),
    .insert_entry (insert_entry),
    .cancel       (cancel),
    .cancel_uid   (cancel_uid),
    .head_pop     (head_pop),
    .reject_pop   (reject_pop),
    .entries      (entries),
    .entry_vld    (entry_vld),
    .head_vld     (head_vld),
    .head         (head),
    .reject_vld   (reject_vld),
    .reject       (reject),
    .cancel_hit   (cancel_hit),
    .cancel_entry (cancel_entry)
  );

  lm_query_fsm u_fsm (
    .clk       (clk),
    .rst       (rst),
    .qry_vld   (qry_vld),
    .scan_last (scan_last),
    .qry_busy  (qry_busy),
    .scan_clr  (scan_clr),
    .scan_step (scan_step),
    .rsp_load  (rsp_load)
  );

  lm_scan_counter #(.N(N)) u_counter (
    .clk       (clk),
    .rst       (rst),
    .scan_clr  (scan_clr),
    .scan_step (scan_step),
    .scan_idx  (scan_idx),
    .scan_last (scan_last)
  );

  lm_depth_accum #(.N(N), .is_ask(is_ask)) u_accum (
    .clk         (clk),
    .rst         (rst),
    .qry_vld     (qry_vld),
    .qry_cmd     (qry_cmd),
    .scan_clr    (scan_clr),
    .scan_step   (scan_step),
    .scan_idx    (scan_idx),
    .entries     (entries),
    .entry_vld   (entry_vld),
    .rsp_load    (rsp_load),
    .qry_rsp_vld (qry_rsp_vld),
    .qry_rsp     (qry_rsp)
  );

endmodule

// File: tb/lm_table_assert.sv
module lm_table_assert #(
  parameter int N = 8
) (
  input logic clk,
  input logic rst,
  input logic insert,
  input logic cancel,
  input logic head_pop,
  input logic qry_vld,
  input logic head_vld,
  input logic reject_vld,
  input logic qry_busy,
  input logic qry_rsp_vld
);

  int fail_count = 0;

  // At most one table command per cycle
  a_one_cmd: assert property (@(posedge clk) disable iff (rst)
    $onehot0({insert, cancel, head_pop}))
    else begin
      fail_count++;
      $error("more than one table command in one cycle");
    end

  // Nothing new while a scan runs
  a_busy_quiet: assert property (@(posedge clk) disable iff (rst)
    qry_busy |-> !(insert || cancel || head_pop || qry_vld))
    else begin
      fail_count++;
      $error("command issued while a query was busy");
    end

  // Response rises N+1 cycles after the accepting edge
  a_rsp_time: assert property (@(posedge clk) disable iff (rst)
    $rose(qry_rsp_vld) |-> $past(qry_vld && !qry_busy, N + 2))
    else begin
      fail_count++;
      $error("query response rose at the wrong cycle");
    end

  a_reset_state: assert property (@(posedge clk)
    $fell(rst) |-> !head_vld && !reject_vld && !qry_busy && !qry_rsp_vld)
    else begin
      fail_count++;
      $error("outputs not idle after reset");
    end

endmodule

bind lm_table_top lm_table_assert #(.N(N)) u_assert (
  .clk         (clk),
  .rst         (rst),
  .insert      (insert),
  .cancel      (cancel),
  .head_pop    (head_pop),
  .qry_vld     (qry_vld),
  .head_vld    (head_vld),
  .reject_vld  (reject_vld),
  .qry_busy    (qry_busy),
  .qry_rsp_vld (qry_rsp_vld)
);

// File: tb/lm_table_checker.sv
module lm_table_checker #(
  parameter int N      = 8,
  parameter bit is_ask = 1'b1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              insert,
  input  lm_pkg::entry_t    insert_entry,
  input  logic              cancel,
  input  lm_pkg::uid_t      cancel_uid,
  input  logic              head_pop,
  input  logic              reject_pop,
  input  logic              qry_vld,
  input  lm_pkg::qry_cmd_t  qry_cmd,
  input  logic              head_vld,
  input  lm_pkg::entry_t    head,
  input  logic              reject_vld,
  input  lm_pkg::entry_t    reject,
  input  logic              cancel_hit,
  input  lm_pkg::entry_t    cancel_entry,
  input  logic              qry_busy,
  input  logic              qry_rsp_vld,
  input  lm_pkg::qry_rsp_t  qry_rsp,
  output int                err_count,
  output int                chk_count
);

  import lm_pkg::*;

  // Model of the resting orders, index 0 is best
  entry_t   model [N];
  int       depth;
  entry_t   m_rej;
  logic     m_rej_vld;
  // Query sequencing as seen from the ports
  logic     m_busy;
  int       busy_left;
  logic     m_rsp_vld;
  qry_rsp_t m_rsp;
  qry_rsp_t pend_rsp;

  int errs   = 0;
  int checks = 0;

  assign err_count = errs;
  assign chk_count = checks;

  // Strictly better price on this side
  function automatic logic ranks_before(price_t a, price_t b);
    return is_ask ? (a < b) : (a > b);
  endfunction

  // New order goes ahead of the first entry it strictly beats
  function automatic int insert_slot(price_t p);
    for (int i = 0; i < depth; i++) begin
      if (ranks_before(p, model[i].price)) begin
        return i;
      end
    end
    return depth;
  endfunction

  function automatic int find_uid(uid_t u);
    for (int i = 0; i < depth; i++) begin
      if (model[i].uid == u) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Expected answer for a depth query on the current model
  function automatic qry_rsp_t depth_sum(qry_cmd_t c);
    accum_t   sum;
    qry_rsp_t r;
    sum = '0;
    for (int i = 0; i < depth; i++) begin
      if (model[i].price == c.price || ranks_before(model[i].price, c.price)) begin
        sum = sum + accum_t'(model[i].quantity);
      end
    end
    r.qty   = sum;
    r.is_ge = (sum >= accum_t'(c.quantity));
    return r;
  endfunction

  task automatic verify_bit(string name, logic exp, logic act);
    checks++;
    if (exp !== act) begin
      errs++;
      $display("[ERROR] t=%0t %s expected=%0b actual=%0b", $time, name, exp, act);
    end
  endtask

  task automatic compare_word(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errs++;
      $display("[ERROR] t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  // Ports against the model state before this edge
  task automatic score_outputs();
    int hit_idx;
    hit_idx = find_uid(cancel_uid);
    verify_bit("head_vld", depth > 0, head_vld);
    if (depth > 0) begin
      compare_word("head", model[0], head);
    end
    verify_bit("reject_vld", m_rej_vld, reject_vld);
    if (m_rej_vld) begin
      compare_word("reject", m_rej, reject);
    end
    verify_bit("qry_busy", m_busy, qry_busy);
    verify_bit("qry_rsp_vld", m_rsp_vld, qry_rsp_vld);
    if (m_rsp_vld) begin
      compare_word("qry_rsp", 32'(m_rsp), 32'(qry_rsp));
    end
    // Cancel result is combinational in the strobe cycle
    verify_bit("cancel_hit", cancel && hit_idx >= 0, cancel_hit);
    if (cancel && hit_idx >= 0) begin
      compare_word("cancel_entry", model[hit_idx], cancel_entry);
    end
  endtask

  task automatic advance_model();
    int   pos;
    int   idx;
    logic overflow;
    overflow = 1'b0;
    if (insert) begin
      pos = insert_slot(insert_entry.price);
      if (depth == N && pos == N) begin
        m_rej    = insert_entry;
        overflow = 1'b1;
      end else begin
        if (depth == N) begin
          // Worst resting order leaves the table
          m_rej    = model[N-1];
          overflow = 1'b1;
          depth    = N - 1;
        end
        for (int i = depth; i > pos; i--) begin
          model[i] = model[i-1];
        end
        model[pos] = insert_entry;
        depth++;
      end
    end else if (cancel) begin
      idx = find_uid(cancel_uid);
      if (idx >= 0) begin
        for (int i = idx; i < depth - 1; i++) begin
          model[i] = model[i+1];
        end
        depth--;
      end
    end else if (head_pop && depth > 0) begin
      for (int i = 0; i < depth - 1; i++) begin
        model[i] = model[i+1];
      end
      depth--;
    end
    // Overflow wins over a pop in the same cycle
    if (overflow) begin
      m_rej_vld = 1'b1;
    end else if (reject_pop) begin
      m_rej_vld = 1'b0;
    end
    if (m_busy) begin
      busy_left--;
      if (busy_left == 0) begin
        m_busy    = 1'b0;
        m_rsp_vld = 1'b1;
        m_rsp     = pend_rsp;
      end
    end else if (qry_vld) begin
      // Answer due N+1 cycles after this edge
      m_busy    = 1'b1;
      busy_left = N + 1;
      m_rsp_vld = 1'b0;
      pend_rsp  = depth_sum(qry_cmd);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      depth     = 0;
      m_rej_vld = 1'b0;
      m_busy    = 1'b0;
      busy_left = 0;
      m_rsp_vld = 1'b0;
    end else begin
      score_outputs();
      advance_model();
    end
  end

endmodule

// File: tb/lm_table_tb.sv
module lm_table_tb;

  import lm_pkg::*;

  localparam int N           = 8;
  localparam int RST_CYCLES  = 8;
  localparam int OPS         = 400;
  localparam int RANDOM_OPS  = 360;
  // Worst case per operation is a full query scan plus margin
  localparam int CYCLE_LIMIT = OPS * (N + 3) + RST_CYCLES;

  logic      clk = 1'b0;
  logic      rst;
  logic      insert;
  entry_t    insert_entry;
  logic      cancel;
  uid_t      cancel_uid;
  logic      head_pop;
  logic      reject_pop;
  logic      qry_vld;
  qry_cmd_t  qry_cmd;
  logic      head_vld;
  entry_t    head;
  logic      reject_vld;
  entry_t    reject;
  logic      cancel_hit;
  entry_t    cancel_entry;
  logic      qry_busy;
  logic      qry_rsp_vld;
  qry_rsp_t  qry_rsp;

  int          err_count;
  int          chk_count;
  int          cycle = 0;
  logic [31:0] rng;
  uid_t        next_uid;
  int unsigned pick;

  always #10 clk = ~clk;

  lm_table_top #(.N(N), .is_ask(1'b1)) dut0 (
    .clk          (clk),
    .rst          (rst),
    .insert       (insert),
    .insert_entry (insert_entry),
    .cancel       (cancel),
    .cancel_uid   (cancel_uid),
    .head_pop     (head_pop),
    .reject_pop   (reject_pop),
    .qry_vld      (qry_vld),
    .qry_cmd      (qry_cmd),
    .head_vld     (head_vld),
    .head         (head),
    .reject_vld   (reject_vld),
    .reject       (reject),
    .cancel_hit   (cancel_hit),
    .cancel_entry (cancel_entry),
    .qry_busy     (qry_busy),
    .qry_rsp_vld  (qry_rsp_vld),
    .qry_rsp      (qry_rsp)
  );

  lm_table_checker #(.N(N), .is_ask(1'b1)) u_checker (
    .clk          (clk),
    .rst          (rst),
    .insert       (insert),
    .insert_entry (insert_entry),
    .cancel       (cancel),
    .cancel_uid   (cancel_uid),
    .head_pop     (head_pop),
    .reject_pop   (reject_pop),
    .qry_vld      (qry_vld),
    .qry_cmd      (qry_cmd),
    .head_vld     (head_vld),
    .head         (head),
    .reject_vld   (reject_vld),
    .reject       (reject),
    .cancel_hit   (cancel_hit),
    .cancel_entry (cancel_entry),
    .qry_busy     (qry_busy),
    .qry_rsp_vld  (qry_rsp_vld),
    .qry_rsp      (qry_rsp),
    .err_count    (err_count),
    .chk_count    (chk_count)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int unsigned rand_below(int unsigned n);
    rng = xorshift32(rng);
    return rng % n;
  endfunction

  // Narrow price band so equal prices show up often
  function automatic price_t random_price();
    return 16'(100 + rand_below(16));
  endfunction

  // Strobes are held for exactly one sampling edge
  task automatic end_cycle();
    @(posedge clk);
    #2;
    insert     = 1'b0;
    cancel     = 1'b0;
    head_pop   = 1'b0;
    reject_pop = 1'b0;
    qry_vld    = 1'b0;
  endtask

  task automatic place_order(price_t p, quantity_t q);
    insert_entry = '{uid: next_uid, price: p, quantity: q};
    insert       = 1'b1;
    next_uid++;
    end_cycle();
  endtask

  task automatic cancel_order(uid_t u);
    cancel_uid = u;
    cancel     = 1'b1;
    end_cycle();
  endtask

  task automatic pop_head();
    head_pop = 1'b1;
    end_cycle();
  endtask

  task automatic pop_reject();
    reject_pop = 1'b1;
    end_cycle();
  endtask

  task automatic run_query(price_t p, quantity_t q);
    qry_cmd = '{price: p, quantity: q};
    qry_vld = 1'b1;
    end_cycle();
    // Response flag marks the end of the scan, timeout guards a stuck FSM
    while (!qry_rsp_vld) begin
      @(posedge clk);
      #2;
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle++;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    insert       = 1'b0;
    insert_entry = '0;
    cancel       = 1'b0;
    cancel_uid   = '0;
    head_pop     = 1'b0;
    reject_pop   = 1'b0;
    qry_vld      = 1'b0;
    qry_cmd      = '0;
    rst          = 1'b1;
    rng          = 32'hd0a0;
    next_uid     = 8'd1;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    // Fill the table, three orders share price 110
    place_order(16'd120, 8'd10);
    place_order(16'd110, 8'd20);
    place_order(16'd130, 8'd5);
    place_order(16'd110, 8'd7);
    place_order(16'd105, 8'd12);
    place_order(16'd140, 8'd9);
    place_order(16'd110, 8'd3);
    place_order(16'd125, 8'd30);
    run_query(16'd115, 8'd30);
    // New order ranks last and is rejected itself
    place_order(16'd150, 8'd4);
    pop_reject();
    // New best order pushes the tail out
    place_order(16'd100, 8'd15);
    pop_reject();
    cancel_order(8'd3);
    cancel_order(8'hf0);
    run_query(16'd200, 8'd255);
    // Drain in priority order
    while (head_vld) begin
      pop_head();
    end
    pop_head();
    run_query(16'd200, 8'd1);

    for (int i = 0; i < RANDOM_OPS; i++) begin
      if (reject_vld) begin
        pop_reject();
      end else begin
        pick = rand_below(20);
        if (pick < 8 && next_uid < 8'd240) begin
          place_order(random_price(), 8'(1 + rand_below(40)));
        end else if (pick < 11) begin
          // Recent uids, some resting and some gone
          cancel_order(next_uid - 8'(1 + rand_below(12)));
        end else if (pick < 14) begin
          pop_head();
        end else if (pick < 17) begin
          run_query(16'(98 + rand_below(20)), 8'(rand_below(120)));
        end else begin
          end_cycle();
        end
      end
    end

    repeat (3) end_cycle();
    $display("Checks: %0d  errors: %0d  assertion failures: %0d",
             chk_count, err_count, dut0.u_assert.fail_count);
    if (err_count == 0 && dut0.u_assert.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
hdl/lm_pkg.sv
hdl/lm_sorted_table.sv
hdl/lm_query_fsm.sv
hdl/lm_scan_counter.sv
hdl/lm_depth_accum.sv
hdl/lm_table_top.sv
tb/lm_table_assert.sv
tb/lm_table_checker.sv
tb/lm_table_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module lm_table_tb -f build.f \
  && ./obj_dir/Vlm_table_tb +verilator+error+limit+1000 > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q '^Result: PASSED$' sim.log && echo "run ok" || { echo "run failed"; exit 1; }
